// ==== hdl/axi_mm_defines.svh ====
////////////////////////////////////////////////////////////
// Widths, FIFO depth and link-up delay for the AXI MM
// credit link
////////////////////////////////////////////////////////////

`ifndef AXI_MM_DEFINES_SVH
`define AXI_MM_DEFINES_SVH

// AXI user-side field widths
`define AXI_ID_W        4
`define AXI_ADDR_W      32
`define AXI_DATA_W      64
`define AXI_LEN_W       8

// Link-side sizing
`define CREDIT_W        8
`define RX_FIFO_DEPTH   8

// Cycles of steady online inputs before traffic is allowed
`define LINK_UP_DELAY   16

`endif

// ==== hdl/axi_mm_pkg.sv ====
////////////////////////////////////////////////////////////
// AXI user-side field types and the five channel structs
////////////////////////////////////////////////////////////

`include "axi_mm_defines.svh"

package axi_mm_pkg;

  ////////////////////////////////////////////////////////////
  // Field types

  typedef logic [`AXI_ID_W-1:0]     axi_id_t;
  typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`AXI_LEN_W-1:0]    axi_len_t;
  typedef logic [2:0]               axi_size_t;
  typedef logic [1:0]               axi_burst_t;
  // One strobe bit per data byte
  typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [1:0]               axi_resp_t;

  ////////////////////////////////////////////////////////////
  // Channel structs

  // Shared by AR and AW
  typedef struct packed {
    axi_id_t    id;
    axi_size_t  size;
    axi_len_t   len;
    axi_burst_t burst;
    axi_addr_t  addr;
  } ax_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    logic      last;
    axi_resp_t resp;
  } r_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_chan_t;

endpackage

// ==== hdl/ll_phy_pkg.sv ====
////////////////////////////////////////////////////////////
// Link-side types for credit counts, PHY frames and link state
////////////////////////////////////////////////////////////

`include "axi_mm_defines.svh"

package ll_phy_pkg;

  typedef logic [`CREDIT_W-1:0] credit_t;

  // Outgoing word, all channels side by side
  typedef struct packed {
    logic                 ar_push;
    axi_mm_pkg::ax_chan_t ar_data;
    logic                 aw_push;
    axi_mm_pkg::ax_chan_t aw_data;
    logic                 w_push;
    axi_mm_pkg::w_chan_t  w_data;
    logic                 r_credit;
    logic                 b_credit;
  } tx_frame_t;

  // Incoming word from the far side
  typedef struct packed {
    logic                r_push;
    axi_mm_pkg::r_chan_t r_data;
    logic                b_push;
    axi_mm_pkg::b_chan_t b_data;
    logic                ar_credit;
    logic                aw_credit;
    logic                w_credit;
  } rx_frame_t;

  // Link-up sequencer states
  typedef enum logic [1:0] {
    LINK_DOWN,
    LINK_WAIT,
    LINK_UP
  } link_state_t;

endpackage

// ==== hdl/ll_link_sync.sv ====
////////////////////////////////////////////////////////////
// Link-up sequencer gated by the two online inputs
////////////////////////////////////////////////////////////

`include "axi_mm_defines.svh"

module ll_link_sync (
  input  logic clk_wr,
  input  logic rst_n,
  input  logic tx_online,
  input  logic rx_online,
  output logic link_up
);

  localparam int unsigned CNT_W = $clog2(`LINK_UP_DELAY + 1);

  ll_phy_pkg::link_state_t state;
  logic [CNT_W-1:0]        hold_cnt;
  logic                    both_online;

  assign both_online = tx_online & rx_online;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      state    <= ll_phy_pkg::LINK_DOWN;
      hold_cnt <= '0;
    end else if (!both_online) begin
      // Any drop restarts the sequence
      state    <= ll_phy_pkg::LINK_DOWN;
      hold_cnt <= '0;
    end else begin
      case (state)
        ll_phy_pkg::LINK_DOWN,
        ll_phy_pkg::LINK_WAIT: begin
          if (hold_cnt == CNT_W'(`LINK_UP_DELAY - 1)) begin
            state <= ll_phy_pkg::LINK_UP;
          end else begin
            state    <= ll_phy_pkg::LINK_WAIT;
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: state <= ll_phy_pkg::LINK_UP;
      endcase
    end
  end

  assign link_up = (state == ll_phy_pkg::LINK_UP);

endmodule

// ==== hdl/ll_transmit.sv ====
////////////////////////////////////////////////////////////
// Credit counter and registered push stage for one TX channel
////////////////////////////////////////////////////////////

module ll_transmit #(
  parameter int unsigned WIDTH = 49
) (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                link_up,
  input  ll_phy_pkg::credit_t init_credit,
  input  logic                credit_in,
  input  logic                valid,
  input  logic [WIDTH-1:0]    data,
  output logic                ready,
  output logic                push,
  output logic [WIDTH-1:0]    push_data
);

  ll_phy_pkg::credit_t credit;
  logic                xfer;

  assign ready = link_up && (credit != '0);
  assign xfer  = valid & ready;

  // Spend on transfer, refill on each returned pulse
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit <= '0;
    end else if (!link_up) begin
      credit <= init_credit;
    end else begin
      case ({xfer, credit_in})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= xfer;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (xfer) begin
      push_data <= data;
    end
  end

endmodule

// ==== hdl/ll_receive.sv ====
////////////////////////////////////////////////////////////
// Receive FIFO with one credit returned per popped beat
////////////////////////////////////////////////////////////

module ll_receive #(
  parameter int unsigned WIDTH = 71,
  parameter int unsigned DEPTH = 8
) (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             link_up,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             valid,
  output logic [WIDTH-1:0] data,
  input  logic             ready,
  output logic             credit_out
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];

  // Extra MSB tells full from empty
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic             full;
  logic             wr_en;
  logic             pop;

  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign valid = (wr_ptr != rd_ptr);
  assign wr_en = push & ~full;
  assign pop   = valid & ready;

  // First-word-fall-through read
  assign data = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr[PTR_W-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!link_up) begin
      // Drop whatever was queued while the link is down
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit return

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit_out <= 1'b0;
    end else begin
      credit_out <= pop;
    end
  end

endmodule

// ==== hdl/ll_phy_frame.sv ====
////////////////////////////////////////////////////////////
// TX word assembly and registered capture of the RX word
////////////////////////////////////////////////////////////

module ll_phy_frame (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  logic                  ar_push,
  input  logic                  aw_push,
  input  logic                  w_push,
  input  axi_mm_pkg::ax_chan_t  ar_data,
  input  axi_mm_pkg::ax_chan_t  aw_data,
  input  axi_mm_pkg::w_chan_t   w_data,
  input  logic                  r_credit,
  input  logic                  b_credit,
  output ll_phy_pkg::tx_frame_t tx_phy,
  input  ll_phy_pkg::rx_frame_t rx_phy,
  output ll_phy_pkg::rx_frame_t rx_frame
);

  ////////////////////////////////////////////////////////////
  // Transmit word, straight from the channel registers

  always_comb begin
    tx_phy.ar_push  = ar_push;
    tx_phy.ar_data  = ar_data;
    tx_phy.aw_push  = aw_push;
    tx_phy.aw_data  = aw_data;
    tx_phy.w_push   = w_push;
    tx_phy.w_data   = w_data;
    tx_phy.r_credit = r_credit;
    tx_phy.b_credit = b_credit;
  end

  ////////////////////////////////////////////////////////////
  // Receive capture

  // Register the whole receive word every edge
  always_ff @(posedge clk_wr) begin
    rx_frame <= rx_phy;
    if (!rst_n) begin
      rx_frame.r_push    <= 1'b0;
      rx_frame.b_push    <= 1'b0;
      rx_frame.ar_credit <= 1'b0;
      rx_frame.aw_credit <= 1'b0;
      rx_frame.w_credit  <= 1'b0;
    end
  end

endmodule

// ==== hdl/axi_mm_master_top.sv ====
////////////////////////////////////////////////////////////
// AXI MM master top level with the link-up sequencer,
// three TX channels, two RX channels and the framer
////////////////////////////////////////////////////////////

`include "axi_mm_defines.svh"

module axi_mm_master_top (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  // Link control
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  ll_phy_pkg::credit_t   init_ar_credit,
  input  ll_phy_pkg::credit_t   init_aw_credit,
  input  ll_phy_pkg::credit_t   init_w_credit,

  // AR and AW
  input  axi_mm_pkg::ax_chan_t  ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  axi_mm_pkg::ax_chan_t  aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,

  // W
  input  axi_mm_pkg::w_chan_t   w,
  input  logic                  w_valid,
  output logic                  w_ready,

  // R and B
  output axi_mm_pkg::r_chan_t   r,
  output logic                  r_valid,
  input  logic                  r_ready,
  output axi_mm_pkg::b_chan_t   b,
  output logic                  b_valid,
  input  logic                  b_ready,

  // PHY words
  output ll_phy_pkg::tx_frame_t tx_phy,
  input  ll_phy_pkg::rx_frame_t rx_phy
);

  localparam int unsigned AX_W = $bits(axi_mm_pkg::ax_chan_t);
  localparam int unsigned W_W  = $bits(axi_mm_pkg::w_chan_t);
  localparam int unsigned R_W  = $bits(axi_mm_pkg::r_chan_t);
  localparam int unsigned B_W  = $bits(axi_mm_pkg::b_chan_t);

  logic                  link_up;
  logic                  ar_push;
  logic                  aw_push;
  logic                  w_push;
  axi_mm_pkg::ax_chan_t  ar_push_data;
  axi_mm_pkg::ax_chan_t  aw_push_data;
  axi_mm_pkg::w_chan_t   w_push_data;
  logic                  r_credit;
  logic                  b_credit;
  ll_phy_pkg::rx_frame_t rx_frame;

  ll_link_sync u_link_sync (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .link_up   (link_up)
  );

  ////////////////////////////////////////////////////////////
  // Outgoing channels

  ll_transmit #(.WIDTH(AX_W)) u_tx_ar (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .init_credit (init_ar_credit),
    .credit_in   (rx_frame.ar_credit),
    .valid       (ar_valid),
    .data        (AX_W'(ar)),
    .ready       (ar_ready),
    .push        (ar_push),
    .push_data   (ar_push_data)
  );

  ll_transmit #(.WIDTH(AX_W)) u_tx_aw (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .init_credit (init_aw_credit),
    .credit_in   (rx_frame.aw_credit),
    .valid       (aw_valid),
    .data        (AX_W'(aw)),
    .ready       (aw_ready),
    .push        (aw_push),
    .push_data   (aw_push_data)
  );

  ll_transmit #(.WIDTH(W_W)) u_tx_w (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .init_credit (init_w_credit),
    .credit_in   (rx_frame.w_credit),
    .valid       (w_valid),
    .data        (W_W'(w)),
    .ready       (w_ready),
    .push        (w_push),
    .push_data   (w_push_data)
  );

  ////////////////////////////////////////////////////////////
  // Incoming channels

  ll_receive #(.WIDTH(R_W), .DEPTH(`RX_FIFO_DEPTH)) u_rx_r (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .link_up    (link_up),
    .push       (rx_frame.r_push),
    .push_data  (R_W'(rx_frame.r_data)),
    .valid      (r_valid),
    .data       (r),
    .ready      (r_ready),
    .credit_out (r_credit)
  );

  ll_receive #(.WIDTH(B_W), .DEPTH(`RX_FIFO_DEPTH)) u_rx_b (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .link_up    (link_up),
    .push       (rx_frame.b_push),
    .push_data  (B_W'(rx_frame.b_data)),
    .valid      (b_valid),
    .data       (b),
    .ready      (b_ready),
    .credit_out (b_credit)
  );

  ll_phy_frame u_phy_frame (
    .clk_wr   (clk_wr),
    .rst_n    (rst_n),
    .ar_push  (ar_push),
    .aw_push  (aw_push),
    .w_push   (w_push),
    .ar_data  (ar_push_data),
    .aw_data  (aw_push_data),
    .w_data   (w_push_data),
    .r_credit (r_credit),
    .b_credit (b_credit),
    .tx_phy   (tx_phy),
    .rx_phy   (rx_phy),
    .rx_frame (rx_frame)
  );

endmodule

// ==== verification/axi_mm_master_properties.sv ====
////////////////////////////////////////////////////////////
// Concurrent protocol assertions for the AXI MM master
////////////////////////////////////////////////////////////

module axi_mm_master_properties (
  input logic                  clk_wr,
  input logic                  rst_n,
  input logic                  link_up,
  input ll_phy_pkg::tx_frame_t tx_phy,
  input axi_mm_pkg::r_chan_t   r,
  input logic                  r_valid,
  input logic                  r_ready,
  input axi_mm_pkg::b_chan_t   b,
  input logic                  b_valid,
  input logic                  b_ready,
  input logic                  r_full,
  input logic                  r_push,
  input logic                  b_full,
  input logic                  b_push
);

  // Number of assertion failures so far
  int unsigned failures = 0;

  // Nothing leaves while the link is down
  a_no_push_down: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !link_up |-> !(tx_phy.ar_push || tx_phy.aw_push || tx_phy.w_push))
    else begin
      $error("push on tx_phy while link_up is low");
      failures++;
    end

  // User-side R and B hold until taken
  a_r_stable: assert property (@(posedge clk_wr) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      $error("R beat changed or dropped before it was taken");
      failures++;
    end
  a_b_stable: assert property (@(posedge clk_wr) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
      $error("B beat changed or dropped before it was taken");
      failures++;
    end

  // Far side must respect the credits
  a_r_no_overflow: assert property (@(posedge clk_wr) disable iff (!rst_n)
    r_full |-> !r_push)
    else begin
      $error("R push while the R FIFO is full");
      failures++;
    end
  a_b_no_overflow: assert property (@(posedge clk_wr) disable iff (!rst_n)
    b_full |-> !b_push)
    else begin
      $error("B push while the B FIFO is full");
      failures++;
    end

endmodule

// ==== verification/tb_axi_mm_master.sv ====
////////////////////////////////////////////////////////////
// Far-side link model, stimulus, reference function and
// checker for the AXI MM master
////////////////////////////////////////////////////////////

`include "axi_mm_defines.svh"

module tb_axi_mm_master;

  // Cycle budget of each test
  localparam int unsigned T_LINK = 40;
  localparam int unsigned T_CRED = 60;
  localparam int unsigned T_TX   = 60;
  localparam int unsigned T_R    = 60;
  localparam int unsigned T_B    = 80;
  localparam int unsigned LIMIT  = 2 * (T_LINK + T_CRED + T_TX + T_R + T_B) + `LINK_UP_DELAY;

  logic clk_wr = 1'b0;
  logic rst_n;
  logic tx_online, rx_online;
  ll_phy_pkg::credit_t init_ar_credit, init_aw_credit, init_w_credit;
  axi_mm_pkg::ax_chan_t ar, aw;
  axi_mm_pkg::w_chan_t w;
  axi_mm_pkg::r_chan_t r;
  axi_mm_pkg::b_chan_t b;
  logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic r_valid, r_ready, b_valid, b_ready;
  ll_phy_pkg::tx_frame_t tx_phy;
  ll_phy_pkg::rx_frame_t rx_phy;

  logic [31:0]  seed = 32'hf938;
  int unsigned  cycle = 0;
  int unsigned  errors = 0;
  int unsigned  tests_run = 0;
  int unsigned  tests_failed = 0;
  string        test_name;
  int unsigned  ar_pushes = 0;
  int unsigned  r_sent = 0, r_credits = 0, b_sent = 0, b_credits = 0;
  logic [76:0]  exp_ar[$], exp_aw[$], exp_w[$], exp_r[$], exp_b[$];
  int unsigned  cyc_ar[$], cyc_aw[$], cyc_w[$];

  always #5 clk_wr = ~clk_wr;

  axi_mm_master_top dut0 (.*);

  bind axi_mm_master_top axi_mm_master_properties u_props (
    .clk_wr (clk_wr), .rst_n (rst_n), .link_up (link_up), .tx_phy (tx_phy),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready),
    .r_full (u_rx_r.full), .r_push (u_rx_r.push),
    .b_full (u_rx_b.full), .b_push (u_rx_b.push)
  );

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [127:0] rand_bits();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // Link carries each accepted beat unchanged and in order
  function automatic logic [76:0] expected_beat(input logic [76:0] accepted);
    return accepted;
  endfunction

  task automatic check_value(input string what, input logic [76:0] exp, input logic [76:0] got);
    assert (got == exp) else begin
      $display("** Error %s %s: expected %h actual %h", test_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_tx(input string what, input logic [76:0] acc, input logic [76:0] got,
                          input int unsigned acc_cyc);
    check_value(what, expected_beat(acc), got);
    assert (cycle == acc_cyc + 1) else begin
      $display("** Error %s %s push cycle: expected %0d actual %0d", test_name, what,
               acc_cyc + 1, cycle);
      errors++;
    end
  endtask

  task automatic unexpected_beat(input string what);
    $display("%s: %s beat seen with nothing expected", test_name, what);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Checker and timeout

  always @(posedge clk_wr) begin
    cycle++;
    if (cycle >= LIMIT) begin
      $display("Timeout after %0d cycles in test %s", cycle, test_name);
      $display("Something failed");
      $finish;
    end else if (rst_n) begin
      if (ar_valid && ar_ready) begin
        exp_ar.push_back(77'(ar));
        cyc_ar.push_back(cycle);
      end
      if (aw_valid && aw_ready) begin
        exp_aw.push_back(77'(aw));
        cyc_aw.push_back(cycle);
      end
      if (w_valid && w_ready) begin
        exp_w.push_back(77'(w));
        cyc_w.push_back(cycle);
      end
      if (tx_phy.ar_push) begin
        ar_pushes++;
        assert (exp_ar.size() != 0) else unexpected_beat("AR");
        if (exp_ar.size() != 0) begin
          check_tx("AR", exp_ar.pop_front(), 77'(tx_phy.ar_data), cyc_ar.pop_front());
        end
      end
      if (tx_phy.aw_push) begin
        assert (exp_aw.size() != 0) else unexpected_beat("AW");
        if (exp_aw.size() != 0) begin
          check_tx("AW", exp_aw.pop_front(), 77'(tx_phy.aw_data), cyc_aw.pop_front());
        end
      end
      if (tx_phy.w_push) begin
        assert (exp_w.size() != 0) else unexpected_beat("W");
        if (exp_w.size() != 0) begin
          check_tx("W", exp_w.pop_front(), 77'(tx_phy.w_data), cyc_w.pop_front());
        end
      end
      if (r_valid && r_ready) begin
        assert (exp_r.size() != 0) else unexpected_beat("R");
        if (exp_r.size() != 0) begin
          check_value("R", expected_beat(exp_r.pop_front()), 77'(r));
        end
      end
      if (b_valid && b_ready) begin
        assert (exp_b.size() != 0) else unexpected_beat("B");
        if (exp_b.size() != 0) begin
          check_value("B", expected_beat(exp_b.pop_front()), 77'(b));
        end
      end
      r_credits += tx_phy.r_credit;
      b_credits += tx_phy.b_credit;
    end
  end

  ////////////////////////////////////////////////////////////
  // Far side and user-port drivers

  task automatic push_r(input axi_mm_pkg::r_chan_t beat);
    while (`RX_FIFO_DEPTH - r_sent + r_credits == 0) @(negedge clk_wr);
    rx_phy.r_push = 1'b1;
    rx_phy.r_data = beat;
    exp_r.push_back(77'(beat));
    r_sent++;
    @(negedge clk_wr);
    rx_phy.r_push = 1'b0;
  endtask

  task automatic push_b(input axi_mm_pkg::b_chan_t beat);
    while (`RX_FIFO_DEPTH - b_sent + b_credits == 0) @(negedge clk_wr);
    rx_phy.b_push = 1'b1;
    rx_phy.b_data = beat;
    exp_b.push_back(77'(beat));
    b_sent++;
    @(negedge clk_wr);
    rx_phy.b_push = 1'b0;
  endtask

  task automatic send_ar(input axi_mm_pkg::ax_chan_t v);
    ar = v;
    ar_valid = 1'b1;
    while (!ar_ready) @(negedge clk_wr);
    @(negedge clk_wr);
    ar_valid = 1'b0;
  endtask

  task automatic send_aw(input axi_mm_pkg::ax_chan_t v);
    aw = v;
    aw_valid = 1'b1;
    while (!aw_ready) @(negedge clk_wr);
    @(negedge clk_wr);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input axi_mm_pkg::w_chan_t v);
    w = v;
    w_valid = 1'b1;
    while (!w_ready) @(negedge clk_wr);
    @(negedge clk_wr);
    w_valid = 1'b0;
  endtask

  task automatic expect_eq(input string what, input int unsigned exp, input int unsigned got);
    assert (got == exp) else begin
      $display("** Error %s %s: expected %0d actual %0d", test_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != 0) tests_failed++;
    $display("%s: %s (%0d errors)", test_name, (errors == 0) ? "PASS" : "FAIL", errors);
    errors = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    int unsigned start;
    logic [31:0] tmp;
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_ar_credit = 8'd3;
    init_aw_credit = 8'd8;
    init_w_credit = 8'd8;
    {ar, aw, w} = '0;
    {ar_valid, aw_valid, w_valid, r_ready, b_ready} = '0;
    rx_phy = '0;
    test_name = "reset";
    repeat (3) @(negedge clk_wr);
    rst_n = 1'b1;

    // 1. Link-up sequence
    test_name = "link_up";
    tx_online = 1'b1;
    repeat (20) begin
      @(negedge clk_wr);
      expect_eq("ready with rx_online low", 0, ar_ready | aw_ready | w_ready);
    end
    rx_online = 1'b1;
    for (int i = 1; i <= `LINK_UP_DELAY; i++) begin
      @(negedge clk_wr);
      expect_eq("readies", (i == `LINK_UP_DELAY), ar_ready & aw_ready & w_ready);
    end
    end_test();

    // 2. AR credit limit
    test_name = "credit_limit";
    repeat (3) send_ar(49'(rand_bits()));
    for (int k = 0; k < 3; k++) begin
      ar = 49'(rand_bits());
      ar_valid = 1'b1;
      repeat (6) begin
        @(negedge clk_wr);
        expect_eq("ar_ready without credit", 0, ar_ready);
      end
      expect_eq("AR pushes", 3 + k, ar_pushes);
      rx_phy.ar_credit = 1'b1;
      @(negedge clk_wr);
      rx_phy.ar_credit = 1'b0;
      while (!ar_ready) @(negedge clk_wr);
      @(negedge clk_wr);
    end
    ar_valid = 1'b0;
    @(negedge clk_wr);
    expect_eq("AR pushes", 6, ar_pushes);
    expect_eq("ar_ready without credit", 0, ar_ready);
    end_test();

    // 3. AR, AW and W transmit
    test_name = "tx_channels";
    rx_phy.ar_credit = 1'b1;
    repeat (4) @(negedge clk_wr);
    rx_phy.ar_credit = 1'b0;
    fork
      repeat (4) send_ar(49'(rand_bits()));
      repeat (6) send_aw(49'(rand_bits()));
      repeat (6) send_w(77'(rand_bits()));
    join
    repeat (3) @(negedge clk_wr);
    expect_eq("beats never pushed", 0, exp_ar.size() + exp_aw.size() + exp_w.size());
    end_test();

    // 4. R with back-pressure
    test_name = "r_backpressure";
    start = r_credits;
    repeat (`RX_FIFO_DEPTH) push_r(71'(rand_bits()));
    repeat (4) @(negedge clk_wr);
    expect_eq("r_valid while held", 1, r_valid);
    expect_eq("R credits while held", 0, r_credits - start);
    r_ready = 1'b1;
    while (exp_r.size() != 0) @(negedge clk_wr);
    repeat (2) @(negedge clk_wr);
    expect_eq("R credits", `RX_FIFO_DEPTH, r_credits - start);
    r_ready = 1'b0;
    end_test();

    // 5. Random B beats with random b_ready
    test_name = "b_receive";
    start = b_credits;
    fork
      repeat (12) push_b(6'(next_rand()));
      repeat (40) begin
        @(negedge clk_wr);
        tmp = next_rand();
        b_ready = tmp[7];
      end
    join
    b_ready = 1'b1;
    while (exp_b.size() != 0) @(negedge clk_wr);
    repeat (2) @(negedge clk_wr);
    expect_eq("B credits", 12, b_credits - start);
    end_test();

    $display("Tests run %0d, failed %0d, assertion failures %0d", tests_run, tests_failed,
             dut0.u_props.failures);
    if (tests_failed == 0 && dut0.u_props.failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/axi_mm_pkg.sv
hdl/ll_phy_pkg.sv
hdl/ll_link_sync.sv
hdl/ll_transmit.sv
hdl/ll_receive.sv
hdl/ll_phy_frame.sv
hdl/axi_mm_master_top.sv
verification/axi_mm_master_properties.sv
verification/tb_axi_mm_master.sv

// ==== Bender.yml ====
package:
  name: axi_mm_master

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_mm_pkg.sv
      - hdl/ll_phy_pkg.sv
      - hdl/ll_link_sync.sv
      - hdl/ll_transmit.sv
      - hdl/ll_receive.sv
      - hdl/ll_phy_frame.sv
      - hdl/axi_mm_master_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/axi_mm_master_properties.sv
      - verification/tb_axi_mm_master.sv
